// ==== buf_pkg.sv ====
`default_nettype none

package buf_pkg;

    // write side is one 32-bit word per access
    localparam int W_DATA_W = 32;
    // read side is one byte per access
    localparam int R_DATA_W = 8;

    // byte lanes per word and the bits needed to pick one
    localparam int LANES  = W_DATA_W / R_DATA_W;
    localparam int LANE_W = $clog2(LANES);

    // 16 words, 64 bytes
    localparam int W_ADDR_W  = 4;
    localparam int R_ADDR_W  = W_ADDR_W + LANE_W;
    localparam int MEM_DEPTH = 2 ** W_ADDR_W;

    // scanner peers sharing the narrow read port
    localparam int N_SCAN = 2;
    localparam int SCAN_W = (N_SCAN > 1) ? $clog2(N_SCAN) : 1;

    // scan length, 1 to 64 bytes
    localparam int LEN_W = R_ADDR_W + 1;

    // one wide write from the host
    typedef struct packed {
        logic                en;
        logic [W_ADDR_W-1:0] addr;
        logic [W_DATA_W-1:0] data;
    } wr_req_t;

    // one scan command, start is a byte address
    typedef struct packed {
        logic [R_ADDR_W-1:0] start;
        logic [LEN_W-1:0]    len;
    } scan_cmd_t;

    // one byte of a scan, last marks the final byte
    typedef struct packed {
        logic [R_DATA_W-1:0] data;
        logic                last;
    } byte_beat_t;

    // scanner FSM
    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_RUN,
        SCAN_DRAIN
    } scan_state_e;

endpackage

`default_nettype wire

// ==== lane_mem_2p.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_mem_2p
    import buf_pkg::*;
(
    input  logic                clk_i,

    // write port, one enable per byte lane
    input  logic [LANES-1:0]    w_en_i,
    input  logic [W_ADDR_W-1:0] w_addr_i,
    input  logic [W_DATA_W-1:0] w_data_i,

    // read port, one enable per byte lane
    input  logic [LANES-1:0]    r_en_i,
    input  logic [W_ADDR_W-1:0] r_addr_i,
    output logic [W_DATA_W-1:0] r_data_o
);

    // one independent byte array per lane
    for (genvar l = 0; l < LANES; l++) begin : g_lane
        logic [R_DATA_W-1:0] mem [MEM_DEPTH];
        logic [R_DATA_W-1:0] rd_q;

        always_ff @(posedge clk_i) begin
            if (w_en_i[l]) begin
                mem[w_addr_i] <= w_data_i[l*R_DATA_W +: R_DATA_W];
            end
        end

        // registered read, holds its value while the lane is idle
        // a read of a word written on the same edge returns the old byte
        always_ff @(posedge clk_i) begin
            if (r_en_i[l]) begin
                rd_q <= mem[r_addr_i];
            end
        end

        assign r_data_o[l*R_DATA_W +: R_DATA_W] = rd_q;
    end

endmodule

`default_nettype wire

// ==== ram_2p_asym.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_2p_asym
    import buf_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,

    // wide write port
    input  wr_req_t             w_req_i,

    // narrow read port
    input  logic                r_en_i,
    input  logic [R_ADDR_W-1:0] r_addr_i,
    output logic [R_DATA_W-1:0] r_data_o,

    // lane memory write port
    output logic [LANES-1:0]    mem_w_en_o,
    output logic [W_ADDR_W-1:0] mem_w_addr_o,
    output logic [W_DATA_W-1:0] mem_w_data_o,

    // lane memory read port
    output logic [LANES-1:0]    mem_r_en_o,
    output logic [W_ADDR_W-1:0] mem_r_addr_o,
    input  logic [W_DATA_W-1:0] mem_r_data_i
);

    logic [LANE_W-1:0] lane;
    logic [LANE_W-1:0] lane_q;

    // a wide write always covers the full word
    assign mem_w_en_o   = {LANES{w_req_i.en}};
    assign mem_w_addr_o = w_req_i.addr;
    assign mem_w_data_o = w_req_i.data;

    // byte address splits into word address and lane index
    assign lane         = r_addr_i[LANE_W-1:0];
    assign mem_r_addr_o = r_addr_i[R_ADDR_W-1:LANE_W];

    // only the addressed lane is read
    assign mem_r_en_o   = LANES'(r_en_i) << lane;

    // lane index follows the registered memory read by one cycle
    // kept while idle so r_data_o stays on the last byte read
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lane_q <= '0;
        end else if (r_en_i) begin
            lane_q <= lane;
        end
    end

    // pick the byte out of the wide word
    // lane 0 is the low byte
    assign r_data_o = mem_r_data_i[lane_q*R_DATA_W +: R_DATA_W];

endmodule

`default_nettype wire

// ==== rd_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rd_arbiter
    import buf_pkg::*;
(
    input  logic                             clk_i,
    input  logic                             rst_n_i,

    // scanner side
    input  logic [N_SCAN-1:0]                req_i,
    input  logic [N_SCAN-1:0][R_ADDR_W-1:0]  addr_i,
    output logic [N_SCAN-1:0]                gnt_o,

    // narrow read port
    output logic                             r_en_o,
    output logic [R_ADDR_W-1:0]              r_addr_o
);

    logic [SCAN_W-1:0] prio_q;
    logic [SCAN_W-1:0] win;

    // search starts at the priority pointer and wraps around
    always_comb begin
        int unsigned idx;
        gnt_o = '0;
        win   = prio_q;
        for (int i = 0; i < N_SCAN; i++) begin
            idx = (int'(prio_q) + i) % N_SCAN;
            if (gnt_o == '0 && req_i[idx]) begin
                gnt_o[idx] = 1'b1;
                win        = SCAN_W'(idx);
            end
        end
    end

    assign r_en_o   = |gnt_o;
    assign r_addr_o = addr_i[win];

    // pointer moves just past the last winner, scanner 0 first after reset
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q <= '0;
        end else if (r_en_o) begin
            prio_q <= SCAN_W'((int'(win) + 1) % N_SCAN);
        end
    end

    a_gnt_onehot: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(gnt_o)
    ) else $error("grant vector not one-hot: %b", gnt_o);

    a_gnt_has_req: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (gnt_o & ~req_i) == '0
    ) else $error("grant %b without request %b", gnt_o, req_i);

endmodule

`default_nettype wire

// ==== byte_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_scanner
    import buf_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,

    // command, one-cycle pulse
    input  logic                go_i,
    input  scan_cmd_t           cmd_i,

    // shared read port
    input  logic                rd_gnt_i,
    input  logic [R_DATA_W-1:0] rd_data_i,
    output logic                rd_req_o,
    output logic [R_ADDR_W-1:0] rd_addr_o,

    // byte stream
    output logic                beat_valid_o,
    output byte_beat_t          beat_o,
    output logic                busy_o
);

    scan_state_e         state_q;
    scan_state_e         state_d;
    logic [R_ADDR_W-1:0] addr_q;
    logic [LEN_W-1:0]    left_q;
    logic                take;
    logic                final_req;
    logic                pend_q;
    logic                pend_last_q;

    // a granted request, and whether it fetches the final byte
    assign take      = rd_req_o && rd_gnt_i;
    assign final_req = (left_q == LEN_W'(1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            SCAN_IDLE: begin
                if (go_i) begin
                    state_d = SCAN_RUN;
                end
            end
            SCAN_RUN: begin
                if (take && final_req) begin
                    state_d = SCAN_DRAIN;
                end
            end
            // final read is in flight, its beat goes out this cycle
            SCAN_DRAIN: begin
                if (pend_q) begin
                    state_d = SCAN_IDLE;
                end
            end
            default: state_d = SCAN_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= SCAN_IDLE;
            addr_q      <= '0;
            left_q      <= '0;
            pend_q      <= 1'b0;
            pend_last_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            pend_q      <= take;
            pend_last_q <= take && final_req;
            if (state_q == SCAN_IDLE && go_i) begin
                addr_q <= cmd_i.start;
                left_q <= cmd_i.len;
            end else if (take) begin
                // byte address wraps at the top of the buffer
                addr_q <= addr_q + R_ADDR_W'(1);
                left_q <= left_q - LEN_W'(1);
            end
        end
    end

    assign rd_req_o  = (state_q == SCAN_RUN);
    assign rd_addr_o = addr_q;
    assign busy_o    = (state_q != SCAN_IDLE);

    // read data is broadcast, only the flagged cycle is ours
    assign beat_valid_o = pend_q;
    assign beat_o.data  = rd_data_i;
    assign beat_o.last  = pend_last_q;

    a_go_when_idle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        go_i |-> !busy_o
    ) else $error("scan command while busy");

    a_last_ends_scan: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (beat_valid_o && beat_o.last) |=> !busy_o
    ) else $error("scanner still busy after last beat");

endmodule

`default_nettype wire

// ==== byte_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_buffer_top
    import buf_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // host write port
    input  wr_req_t                     wr_req_i,

    // scan commands, one per scanner
    input  logic       [N_SCAN-1:0]     scan_go_i,
    input  scan_cmd_t  [N_SCAN-1:0]     scan_cmd_i,

    // byte streams, one per scanner
    output logic       [N_SCAN-1:0]     beat_valid_o,
    output byte_beat_t [N_SCAN-1:0]     beat_o,
    output logic       [N_SCAN-1:0]     busy_o
);

    // scanner to arbiter
    logic [N_SCAN-1:0]               rd_req;
    logic [N_SCAN-1:0][R_ADDR_W-1:0] rd_addr;
    logic [N_SCAN-1:0]               rd_gnt;

    // arbiter to wrapper, and the byte coming back
    logic                            r_en;
    logic [R_ADDR_W-1:0]             r_addr;
    logic [R_DATA_W-1:0]             r_data;

    // wrapper to lane memory
    logic [LANES-1:0]                mem_w_en;
    logic [W_ADDR_W-1:0]             mem_w_addr;
    logic [W_DATA_W-1:0]             mem_w_data;
    logic [LANES-1:0]                mem_r_en;
    logic [W_ADDR_W-1:0]             mem_r_addr;
    logic [W_DATA_W-1:0]             mem_r_data;

    for (genvar s = 0; s < N_SCAN; s++) begin : g_scan
        byte_scanner i_byte_scanner (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .go_i         (scan_go_i[s]),
            .cmd_i        (scan_cmd_i[s]),
            .rd_gnt_i     (rd_gnt[s]),
            .rd_data_i    (r_data),
            .rd_req_o     (rd_req[s]),
            .rd_addr_o    (rd_addr[s]),
            .beat_valid_o (beat_valid_o[s]),
            .beat_o       (beat_o[s]),
            .busy_o       (busy_o[s])
        );
    end

    rd_arbiter i_rd_arbiter (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .req_i    (rd_req),
        .addr_i   (rd_addr),
        .gnt_o    (rd_gnt),
        .r_en_o   (r_en),
        .r_addr_o (r_addr)
    );

    ram_2p_asym i_ram_2p_asym (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .w_req_i      (wr_req_i),
        .r_en_i       (r_en),
        .r_addr_i     (r_addr),
        .r_data_o     (r_data),
        .mem_w_en_o   (mem_w_en),
        .mem_w_addr_o (mem_w_addr),
        .mem_w_data_o (mem_w_data),
        .mem_r_en_o   (mem_r_en),
        .mem_r_addr_o (mem_r_addr),
        .mem_r_data_i (mem_r_data)
    );

    lane_mem_2p i_lane_mem_2p (
        .clk_i    (clk_i),
        .w_en_i   (mem_w_en),
        .w_addr_i (mem_w_addr),
        .w_data_i (mem_w_data),
        .r_en_i   (mem_r_en),
        .r_addr_i (mem_r_addr),
        .r_data_o (mem_r_data)
    );

endmodule

`default_nettype wire

// ==== tb_byte_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_byte_buffer_top
    import buf_pkg::*;
();

    localparam int SCAN_TIMEOUT = 400;

    logic                          clk;
    logic                          rst_n;
    wr_req_t                       wr_req;
    logic       [N_SCAN-1:0]       scan_go;
    scan_cmd_t  [N_SCAN-1:0]       scan_cmd;
    logic       [N_SCAN-1:0]       beat_valid;
    byte_beat_t [N_SCAN-1:0]       beat;
    logic       [N_SCAN-1:0]       busy;

    // byte-wide image of the buffer
    logic [R_DATA_W-1:0] model [2**R_ADDR_W];
    logic [31:0]         lfsr;
    int                  errors;
    int                  tests;

    byte_buffer_top i_byte_buffer_top (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .wr_req_i     (wr_req),
        .scan_go_i    (scan_go),
        .scan_cmd_i   (scan_cmd),
        .beat_valid_o (beat_valid),
        .beat_o       (beat),
        .busy_o       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // one clock, then settle 10 ns past the edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output logic [W_DATA_W-1:0] w);
        w = '0;
        for (int i = 0; i < W_DATA_W; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[W_DATA_W-2:0], lfsr[0]};
        end
    endtask

    // distinct value for every byte address
    function automatic logic [R_DATA_W-1:0] fill_byte(input int b);
        return R_DATA_W'(b * 7 + 49);
    endfunction

    function automatic scan_cmd_t make_cmd(input int start, input int len);
        scan_cmd_t c;
        c.start = R_ADDR_W'(start);
        c.len   = LEN_W'(len);
        return c;
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp_val);
        if (got !== exp_val) begin
            $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp_val);
            errors++;
        end
    endtask

    task automatic check_beat(input string name, input byte_beat_t got,
                              input byte_beat_t exp_val);
        if (got !== exp_val) begin
            $display("CHECK FAILED at %0t ns: %s = {data %h, last %b}, expected {data %h, last %b}",
                     $time, name, got.data, got.last, exp_val.data, exp_val.last);
            errors++;
        end
    endtask

    // full-word write, little-endian byte layout in the model
    task automatic write_word(input logic [W_ADDR_W-1:0] a, input logic [W_DATA_W-1:0] d);
        wr_req.en   = 1'b1;
        wr_req.addr = a;
        wr_req.data = d;
        step();
        wr_req.en   = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            model[{a, LANE_W'(l)}] = d[l*R_DATA_W +: R_DATA_W];
        end
    endtask

    // first_at < 0 skips the latency check, max_idle bounds gaps between beats
    task automatic run_scan(input logic [N_SCAN-1:0] sel, input scan_cmd_t c0,
                            input scan_cmd_t c1, input int first_at, input int max_idle);
        scan_cmd_t  cmd [N_SCAN];
        int         got [N_SCAN];
        int         idle [N_SCAN];
        int         cycles;
        logic       running;
        byte_beat_t exp_beat;
        string      name;
        cmd[0]      = c0;
        cmd[1]      = c1;
        scan_cmd[0] = c0;
        scan_cmd[1] = c1;
        scan_go     = sel;
        for (int s = 0; s < N_SCAN; s++) begin
            got[s]  = 0;
            idle[s] = 0;
        end
        cycles  = 0;
        running = 1'b1;
        while (running) begin
            step();
            scan_go = '0;
            cycles++;
            running = 1'b0;
            for (int s = 0; s < N_SCAN; s++) begin
                name = $sformatf("beat_o[%0d]", s);
                if (beat_valid[s]) begin
                    if (!sel[s] || got[s] >= int'(cmd[s].len)) begin
                        $display("scanner %0d sent a byte it was not asked for at %0t ns",
                                 s, $time);
                        errors++;
                    end else begin
                        if (got[s] == 0 && first_at >= 0 && cycles != first_at) begin
                            $display("scanner %0d first byte after %0d cycles, expected %0d",
                                     s, cycles, first_at);
                            errors++;
                        end
                        exp_beat.data = model[R_ADDR_W'(int'(cmd[s].start) + got[s])];
                        exp_beat.last = (got[s] == int'(cmd[s].len) - 1);
                        check_beat(name, beat[s], exp_beat);
                        got[s]++;
                        idle[s] = 0;
                    end
                end else if (sel[s] && got[s] > 0 && got[s] < int'(cmd[s].len)) begin
                    idle[s]++;
                    if (idle[s] == max_idle + 1) begin
                        $display("scanner %0d went more than %0d cycles without a byte at %0t ns",
                                 s, max_idle, $time);
                        errors++;
                    end
                end
                if (sel[s] && got[s] < int'(cmd[s].len)) begin
                    running = 1'b1;
                end
            end
            if (running && cycles >= SCAN_TIMEOUT) begin
                $display("timeout: scan did not finish within %0d cycles", SCAN_TIMEOUT);
                errors++;
                running = 1'b0;
            end
        end
        // scanners fall idle one cycle after the last beat
        step();
        for (int s = 0; s < N_SCAN; s++) begin
            check_bit($sformatf("busy_o[%0d]", s), busy[s], 1'b0);
            check_bit($sformatf("beat_valid_o[%0d]", s), beat_valid[s], 1'b0);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    task automatic test_reset_idle();
        int e0;
        e0 = errors;
        for (int s = 0; s < N_SCAN; s++) begin
            check_bit($sformatf("busy_o[%0d]", s), busy[s], 1'b0);
            check_bit($sformatf("beat_valid_o[%0d]", s), beat_valid[s], 1'b0);
        end
        repeat (5) begin
            step();
            for (int s = 0; s < N_SCAN; s++) begin
                check_bit($sformatf("beat_valid_o[%0d]", s), beat_valid[s], 1'b0);
            end
        end
        report_test("reset_idle", e0);
    endtask

    task automatic test_full_scan();
        int                  e0;
        logic [W_DATA_W-1:0] d;
        e0 = errors;
        for (int a = 0; a < 2**W_ADDR_W; a++) begin
            for (int l = 0; l < LANES; l++) begin
                d[l*R_DATA_W +: R_DATA_W] = fill_byte(a * LANES + l);
            end
            write_word(W_ADDR_W'(a), d);
        end
        run_scan(2'b01, make_cmd(0, 64), make_cmd(0, 1), 2, 0);
        report_test("full_scan", e0);
    endtask

    task automatic test_unaligned();
        int e0;
        e0 = errors;
        run_scan(2'b10, make_cmd(0, 1), make_cmd(5, 7), 2, 0);
        run_scan(2'b01, make_cmd(62, 2), make_cmd(0, 1), 2, 0);
        report_test("unaligned", e0);
    endtask

    task automatic test_dual_scan();
        int e0;
        e0 = errors;
        // grants alternate, so at most one idle cycle between beats
        run_scan(2'b11, make_cmd(0, 20), make_cmd(33, 24), -1, 1);
        report_test("dual_scan", e0);
    endtask

    task automatic test_overwrite();
        int                  e0;
        logic [W_DATA_W-1:0] d;
        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            rand_word(d);
            write_word(W_ADDR_W'(2 * i + 1), d);
        end
        run_scan(2'b10, make_cmd(0, 1), make_cmd(0, 64), 2, 0);
        report_test("overwrite", e0);
    endtask

    initial begin
        errors   = 0;
        tests    = 0;
        lfsr     = 32'h6432;
        rst_n    = 1'b0;
        wr_req   = '0;
        scan_go  = '0;
        scan_cmd = '0;
        for (int b = 0; b < 2**R_ADDR_W; b++) begin
            model[b] = '0;
        end
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;

        test_reset_idle();
        test_full_scan();
        test_unaligned();
        test_dual_scan();
        test_overwrite();

        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
buf_pkg.sv
lane_mem_2p.sv
ram_2p_asym.sv
rd_arbiter.sv
byte_scanner.sv
byte_buffer_top.sv
tb_byte_buffer_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the byte buffer testbench with Verilator

verilator --binary --timing --assert -Wno-fatal --top-module tb_byte_buffer_top \
    -f tb.f -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1

grep -q "Verification failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Verification passed" sim.log || { echo "FAIL, run ended early, see sim.log"; exit 1; }
echo "PASS"
exit 0
